//--- flist.f
design/isaPkg.sv
design/pipePkg.sv
design/alu.sv
design/claAdder16.sv
design/branchCondition.sv
design/operandForward.sv
design/execute.sv
design/executeUnit.sv
sim/executeTb.sv

//--- sim/executeTb.sv
// testbench for the execute unit
// builds a table of requests with expected responses from a reference
// model, then applies each entry through the four-phase req/ack
// handshake and checks respData field by field
// compile with the packages and RTL from flist.f, top is executeTb
`timescale 1ns/1ps

module executeTb;

   localparam int ACK_TIMEOUT = 20;

   logic              clk = 1'b0;
   logic              rst;
   logic              req;
   pipePkg::execReqS  reqData;
   logic              ack;
   pipePkg::execRespS respData;

   // stimulus table with one entry per test
   string             names[$];
   pipePkg::execReqS  stim[$];
   pipePkg::execRespS expResp[$];

   int passCount = 0;
   int failCount = 0;
   int testErrors;
   bit hung = 1'b0;

   executeUnit DUT (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .reqData  (reqData),
      .ack      (ack),
      .respData (respData)
   );

   always #20 clk = ~clk;

   // operand source as the forwarding rules define it
   function automatic logic [15:0] sourceValue(input isaPkg::fwdSrcE src,
                                              input logic [15:0] regVal,
                                              input pipePkg::fwdDataS f);
      if (src == isaPkg::EX_ALU) return f.exAlu;
      if (src == isaPkg::EX_IMM8) return f.exImm8;
      if (src == isaPkg::EX_ADDPC) return f.exAddPc;
      if (src == isaPkg::MEM_ALU) return f.memAlu;
      if (src == isaPkg::MEM_IMM8) return f.memImm8;
      if (src == isaPkg::MEM_ADDPC) return f.memAddPc;
      if (src == isaPkg::MEM_MEM) return f.memData;
      return regVal;
   endfunction

   // reference model of the whole stage
   function automatic pipePkg::execRespS modelResponse(input pipePkg::execReqS r);
      pipePkg::execRespS e;
      logic [15:0] a, b, fb, res, base, tgt, jumpPc;
      logic [16:0] wide;
      int          sSum;
      int          amt;
      logic        z, s, v, c, t, isBr;
      fb = sourceValue(r.ctrl.fwdB, r.inB, r.fwd);
      a = sourceValue(r.ctrl.fwdA, r.inA, r.fwd);
      b = r.ctrl.stuBase ? r.inB : fb;
      if (r.ctrl.invA) a = ~a;
      if (r.ctrl.invB) b = ~b;
      amt = b[3:0];
      wide = {1'b0, a} + {1'b0, b} + {16'b0, r.ctrl.cin};
      sSum = int'($signed(a)) + int'($signed(b)) + int'(r.ctrl.cin);
      case (r.ctrl.aluOp)
         isaPkg::ROL: res = (a << amt) | (a >> (16 - amt));
         isaPkg::SLL: res = a << amt;
         isaPkg::ROR: res = (a >> amt) | (a << (16 - amt));
         isaPkg::SRL: res = a >> amt;
         isaPkg::ADD: res = wide[15:0];
         isaPkg::OR:  res = a | b;
         isaPkg::XOR: res = a ^ b;
         default:     res = a & b;
      endcase
      z = (res == 16'h0000);
      s = res[15];
      // overflow and carry only exist for ADD
      v = (r.ctrl.aluOp == isaPkg::ADD) && (sSum > 32767 || sSum < -32768);
      c = (r.ctrl.aluOp == isaPkg::ADD) && wide[16];
      case (r.ctrl.brCond)
         isaPkg::BEQZ, isaPkg::SEQ: t = z;
         isaPkg::BNEZ: t = !z;
         isaPkg::BLTZ: t = s;
         isaPkg::BGEZ: t = !s;
         isaPkg::SLT:  t = (s != v);
         isaPkg::SLE:  t = (s != v) || z;
         isaPkg::SCO:  t = c;
         default:      t = 1'b0;
      endcase
      isBr = (r.ctrl.brCond == isaPkg::BEQZ) || (r.ctrl.brCond == isaPkg::BNEZ)
          || (r.ctrl.brCond == isaPkg::BLTZ) || (r.ctrl.brCond == isaPkg::BGEZ);
      base = r.ctrl.aluPcBase ? res : r.incPc;
      tgt = base + (r.ctrl.immSel ? r.imm11 : r.imm8);
      jumpPc = (t && isBr) ? tgt : r.incPc;
      e.aluOut = res;
      e.aluFinal = r.ctrl.setOp ? {15'b0, t} : res;
      e.addPc = r.ctrl.jal ? r.incPc : jumpPc;
      e.newPc = r.ctrl.slbi ? r.incPc : (r.ctrl.aluJmp ? res : jumpPc);
      e.wrtDataOut = (r.ctrl.storeSel == isaPkg::STD_PASS) ? r.wrtDataIn : fb;
      return e;
   endfunction

   // random operands and immediates with distinct forwarded words
   function automatic pipePkg::execReqS baseRequest();
      pipePkg::execReqS r;
      logic [7:0]       i8;
      logic [10:0]      i11;
      r = '0;
      i8 = 8'($urandom);
      i11 = 11'($urandom);
      r.inA = 16'($urandom);
      r.inB = 16'($urandom);
      r.incPc = 16'($urandom);
      r.imm8 = {{8{i8[7]}}, i8};
      r.imm11 = {{5{i11[10]}}, i11};
      r.wrtDataIn = 16'($urandom);
      r.fwd = '{exAlu: 16'h1a01, exImm8: 16'h2b02, exAddPc: 16'h3c03, memAlu: 16'h4d04,
                memImm8: 16'h5e05, memAddPc: 16'h6f06, memData: 16'h7a07};
      return r;
   endfunction

   task automatic addTest(input string name, input pipePkg::execReqS r);
      names.push_back(name);
      stim.push_back(r);
      expResp.push_back(modelResponse(r));
   endtask

   task automatic buildTable();
      pipePkg::execReqS r;
      logic [15:0]      pairA[6] = '{16'h0005, 16'h0003, 16'h0009, 16'h8000, 16'h7fff, 16'h0000};
      logic [15:0]      pairB[6] = '{16'h0005, 16'h0009, 16'h0003, 16'h0001, 16'hffff, 16'h0000};
      logic [4:0]       k;
      // every ALU op as is, with A inverted and as A minus B
      for (int op = 0; op < 8; op++) begin
         for (int vr = 0; vr < 3; vr++) begin
            r = baseRequest();
            r.ctrl.aluOp = isaPkg::aluOpE'(op);
            r.ctrl.invA = (vr == 1);
            r.ctrl.invB = (vr == 2);
            r.ctrl.cin = (vr == 2);
            addTest($sformatf("alu op%0d variant%0d", op, vr), r);
         end
      end
      // 8000 plus 8000 overflows and carries, which only ADD may report
      for (int op = 0; op < 8; op++) begin
         for (int cd = 0; cd < 2; cd++) begin
            r = baseRequest();
            r.ctrl.aluOp = isaPkg::aluOpE'(op);
            r.ctrl.brCond = (cd == 0) ? isaPkg::SLT : isaPkg::SCO;
            r.ctrl.setOp = 1'b1;
            r.inA = 16'h8000;
            r.inB = 16'h8000;
            addTest($sformatf("flags op%0d cond%0d", op, cd), r);
         end
      end
      // each source on A and then on B, ORed with zero
      for (int src = 0; src < 8; src++) begin
         r = baseRequest();
         r.ctrl.aluOp = isaPkg::OR;
         r.ctrl.fwdA = isaPkg::fwdSrcE'(src);
         r.inB = 16'h0000;
         addTest($sformatf("forward A src%0d", src), r);
         r = baseRequest();
         r.ctrl.aluOp = isaPkg::OR;
         r.ctrl.fwdB = isaPkg::fwdSrcE'(src);
         r.inA = 16'h0000;
         addTest($sformatf("forward B src%0d", src), r);
      end
      r = baseRequest();
      r.ctrl.aluOp = isaPkg::ADD;
      r.ctrl.fwdB = isaPkg::MEM_MEM;
      r.ctrl.stuBase = 1'b1;
      addTest("stu base keeps inB", r);
      // conditions on A minus B as set result and as branch
      for (int p = 0; p < 6; p++) begin
         for (int cd = 0; cd < 9; cd++) begin
            for (int so = 0; so < 2; so++) begin
               r = baseRequest();
               r.ctrl.aluOp = isaPkg::ADD;
               r.ctrl.invB = 1'b1;
               r.ctrl.cin = 1'b1;
               r.ctrl.brCond = isaPkg::brCondE'(cd);
               r.ctrl.setOp = so[0];
               r.inA = pairA[p];
               r.inB = pairB[p];
               addTest($sformatf("cond%0d pair%0d set%0d", cd, p, so), r);
            end
         end
      end
      // every mix of immediate, base and PC override bits
      for (int m = 0; m < 32; m++) begin
         k = m[4:0];
         r = baseRequest();
         r.ctrl.aluOp = isaPkg::ADD;
         r.ctrl.brCond = (m % 3 == 0) ? isaPkg::BEQZ : isaPkg::BNEZ;
         r.ctrl.immSel = k[0];
         r.ctrl.aluPcBase = k[1];
         r.ctrl.jal = k[2];
         r.ctrl.aluJmp = k[3];
         r.ctrl.slbi = k[4];
         addTest($sformatf("pc select %0d", m), r);
      end
      for (int st = 0; st < 4; st++) begin
         r = baseRequest();
         r.ctrl.aluOp = isaPkg::AND;
         r.ctrl.storeSel = isaPkg::storeSelE'(st % 2);
         r.ctrl.fwdB = (st < 2) ? isaPkg::REG : isaPkg::MEM_MEM;
         addTest($sformatf("store data %0d", st), r);
      end
   endtask

   task automatic compareWord(input string field, input logic [15:0] expVal,
                              input logic [15:0] actVal);
      assert (actVal === expVal) else begin
         $display("Mismatch at %0t ns: %s expected %h got %h", $time, field, expVal, actVal);
         testErrors++;
      end
   endtask

   task automatic checkResponse(input pipePkg::execRespS e);
      compareWord("respData.aluFinal", e.aluFinal, respData.aluFinal);
      compareWord("respData.newPc", e.newPc, respData.newPc);
      compareWord("respData.addPc", e.addPc, respData.addPc);
      compareWord("respData.aluOut", e.aluOut, respData.aluOut);
      compareWord("respData.wrtDataOut", e.wrtDataOut, respData.wrtDataOut);
   endtask

   // sample ack on falling edges until it reaches level
   task automatic waitAck(input logic level, input string name, output int edges,
                          output bit ok);
      edges = 0;
      ok = 1'b0;
      while (!ok && edges < ACK_TIMEOUT) begin
         @(negedge clk);
         if (ack === level) ok = 1'b1;
         else edges++;
      end
      if (!ok) begin
         $display("Timeout: ack did not %s within %0d cycles in test %s",
                  level ? "rise" : "fall", ACK_TIMEOUT, name);
      end
   endtask

   task automatic runTest(input int i);
      int edges;
      bit ok;
      testErrors = 0;
      @(posedge clk);
      req <= 1'b1;
      reqData <= stim[i];
      waitAck(1'b1, names[i], edges, ok);
      if (!ok) begin
         hung = 1'b1;
         testErrors++;
      end else begin
         // capture edge and then the EVAL edge that raises ack
         assert (edges == 2) else begin
            $display("Mismatch at %0t ns: ack latency expected 2 got %0d", $time, edges);
            testErrors++;
         end
         checkResponse(expResp[i]);
         // response must hold while req stays high
         repeat (2) begin
            @(negedge clk);
            assert (ack === 1'b1) else begin
               $display("ack dropped while req was still high in test %s", names[i]);
               testErrors++;
            end
            checkResponse(expResp[i]);
         end
         @(posedge clk);
         req <= 1'b0;
         waitAck(1'b0, names[i], edges, ok);
         if (!ok) begin
            hung = 1'b1;
            testErrors++;
         end
      end
      if (testErrors == 0) passCount++;
      else failCount++;
      $display("test %-24s %s", names[i], (testErrors == 0) ? "pass" : "FAIL");
   endtask

   initial begin
      rst = 1'b1;
      req = 1'b0;
      reqData = '0;
      void'($urandom(82789));
      buildTable();
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      // reset state before any request
      @(negedge clk);
      testErrors = 0;
      assert (ack === 1'b0) else begin
         $display("Mismatch at %0t ns: ack expected 0 got %b", $time, ack);
         testErrors++;
      end
      checkResponse('0);
      if (testErrors == 0) passCount++;
      else failCount++;
      $display("test %-24s %s", "reset state", (testErrors == 0) ? "pass" : "FAIL");
      for (int i = 0; i < names.size() && !hung; i++) begin
         runTest(i);
      end
      $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
      if (failCount == 0 && !hung) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- design/executeUnit.sv
// standalone execute unit behind a four-phase req/ack handshake
// a request is captured when req is seen in IDLE, evaluated for one
// cycle, then the response is registered and ack raised; ack drops
// once req is seen low, and only then is a new request taken
// respData stays put for the whole time ack is high
`timescale 1ns/1ps

module executeUnit (
   input  logic              clk,
   input  logic              rst,
   input  logic              req,
   input  pipePkg::execReqS  reqData,
   output logic              ack,
   output pipePkg::execRespS respData
);

   typedef enum logic [1:0] {
      IDLE,
      EVAL,
      DONE
   } stateE;

   stateE             state;
   logic              accept;
   pipePkg::execReqS  reqReg;
   pipePkg::execRespS execResp;

   // one item in flight, so accept only from IDLE
   assign accept = (state == IDLE) && req;

   // request payload, held until the next accept
   always_ff @(posedge clk) begin
      if (accept) begin
         reqReg <= reqData;
      end
   end

   execute exec (
      .req  (reqReg),
      .resp (execResp)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= IDLE;
         ack      <= 1'b0;
         respData <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (accept) begin
                  state <= EVAL;
               end
            end
            // captured request has had a cycle to settle
            EVAL: begin
               respData <= execResp;
               ack      <= 1'b1;
               state    <= DONE;
            end
            // hold ack until the requester lets go
            DONE: begin
               if (!req) begin
                  ack   <= 1'b0;
                  state <= IDLE;
               end
            end
            default: begin
               ack   <= 1'b0;
               state <= IDLE;
            end
         endcase
      end
   end

endmodule

//--- design/execute.sv
// combinational execute datapath
// forwards the operands, runs the ALU, tests the condition and adds
// the branch target, then picks next PC, link value and result word
// zero cycles of latency, registered by the top level
`timescale 1ns/1ps

module execute (
   input  pipePkg::execReqS  req,
   output pipePkg::execRespS resp
);

   logic [isaPkg::WORD_W-1:0] aluA;
   logic [isaPkg::WORD_W-1:0] aluB;
   logic [isaPkg::WORD_W-1:0] storeData;
   logic [isaPkg::WORD_W-1:0] aluOut;
   logic                      zero;
   logic                      sign;
   logic                      ovf;
   logic                      carry;
   logic                      condTrue;
   logic                      isBranch;
   logic [isaPkg::WORD_W-1:0] pcBase;
   logic [isaPkg::WORD_W-1:0] immVal;
   logic [isaPkg::WORD_W-1:0] target;
   logic [isaPkg::WORD_W-1:0] jumpPc;
   logic [isaPkg::WORD_W-1:0] addPc;
   logic [isaPkg::WORD_W-1:0] newPc;
   logic [isaPkg::WORD_W-1:0] aluFinal;

   operandForward fwdSel (
      .ctrl      (req.ctrl),
      .inA       (req.inA),
      .inB       (req.inB),
      .wrtDataIn (req.wrtDataIn),
      .fwd       (req.fwd),
      .aluA      (aluA),
      .aluB      (aluB),
      .storeData (storeData)
   );

   alu aluExec (
      .a      (aluA),
      .b      (aluB),
      .cin    (req.ctrl.cin),
      .op     (req.ctrl.aluOp),
      .invA   (req.ctrl.invA),
      .invB   (req.ctrl.invB),
      .result (aluOut),
      .zero   (zero),
      .sign   (sign),
      .ovf    (ovf),
      .carry  (carry)
   );

   branchCondition brCheck (
      .cond     (req.ctrl.brCond),
      .zero     (zero),
      .sign     (sign),
      .ovf      (ovf),
      .carry    (carry),
      .condTrue (condTrue)
   );

   // register-relative jumps add to the ALU result instead of the PC
   assign pcBase = req.ctrl.aluPcBase ? aluOut : req.incPc;
   assign immVal = req.ctrl.immSel ? req.imm11 : req.imm8;

   claAdder16 targetAdd (
      .a   (pcBase),
      .b   (immVal),
      .sum (target)
   );

   // only the four branch forms redirect, set forms just write a bit
   assign isBranch = (req.ctrl.brCond == isaPkg::BEQZ) || (req.ctrl.brCond == isaPkg::BNEZ)
                  || (req.ctrl.brCond == isaPkg::BLTZ) || (req.ctrl.brCond == isaPkg::BGEZ);

   assign jumpPc = (condTrue && isBranch) ? target : req.incPc;

   // link register gets the return address on jal
   assign addPc = req.ctrl.jal ? req.incPc : jumpPc;

   // slbi wins over aluJmp, which wins over the branch/jump path
   assign newPc = req.ctrl.slbi ? req.incPc : (req.ctrl.aluJmp ? aluOut : jumpPc);

   assign aluFinal = req.ctrl.setOp ? {{(isaPkg::WORD_W-1){1'b0}}, condTrue} : aluOut;

   assign resp = '{aluFinal:   aluFinal,
                   newPc:      newPc,
                   addPc:      addPc,
                   aluOut:     aluOut,
                   wrtDataOut: storeData};

endmodule

//--- design/operandForward.sv
// operand selection for the execute stage
// each ALU operand comes from the register value or one of the seven
// forwarded words; store data picks forwarded B or the incoming value
// forwarding control is decided upstream and arrives in ctrl
`timescale 1ns/1ps

module operandForward (
   input  pipePkg::execCtrlS         ctrl,
   input  logic [isaPkg::WORD_W-1:0] inA,
   input  logic [isaPkg::WORD_W-1:0] inB,
   input  logic [isaPkg::WORD_W-1:0] wrtDataIn,
   input  pipePkg::fwdDataS          fwd,
   output logic [isaPkg::WORD_W-1:0] aluA,
   output logic [isaPkg::WORD_W-1:0] aluB,
   output logic [isaPkg::WORD_W-1:0] storeData
);

   logic [isaPkg::WORD_W-1:0] fwdA;
   logic [isaPkg::WORD_W-1:0] fwdB;

   // eight-way pick, same decode for both operands
   function automatic logic [isaPkg::WORD_W-1:0] pickSource(
      input isaPkg::fwdSrcE            src,
      input logic [isaPkg::WORD_W-1:0] regVal,
      input pipePkg::fwdDataS          f
   );
      logic [isaPkg::WORD_W-1:0] val;
      case (src)
         isaPkg::REG:       val = regVal;
         isaPkg::EX_ALU:    val = f.exAlu;
         isaPkg::EX_IMM8:   val = f.exImm8;
         isaPkg::EX_ADDPC:  val = f.exAddPc;
         isaPkg::MEM_ALU:   val = f.memAlu;
         isaPkg::MEM_IMM8:  val = f.memImm8;
         isaPkg::MEM_ADDPC: val = f.memAddPc;
         isaPkg::MEM_MEM:   val = f.memData;
         default:           val = regVal;
      endcase
      return val;
   endfunction

   assign fwdA = pickSource(ctrl.fwdA, inA, fwd);
   assign fwdB = pickSource(ctrl.fwdB, inB, fwd);

   assign aluA = fwdA;

   // stu uses B as a base offset, keep the raw register value
   assign aluB = ctrl.stuBase ? inB : fwdB;

   // the stored word may itself be a forwarded value
   assign storeData = (ctrl.storeSel == isaPkg::STD_FWD) ? fwdB : wrtDataIn;

endmodule

//--- design/branchCondition.sv
// evaluates a branch or set condition on the ALU flags
// branches test the result against zero, set forms rely on the
// request computing A minus B so the flags describe the compare
`timescale 1ns/1ps

module branchCondition (
   input  isaPkg::brCondE cond,
   input  logic           zero,
   input  logic           sign,
   input  logic           ovf,
   input  logic           carry,
   output logic           condTrue
);

   always_comb begin
      case (cond)
         isaPkg::BEQZ: condTrue = zero;
         isaPkg::BNEZ: condTrue = ~zero;
         isaPkg::BLTZ: condTrue = sign;
         isaPkg::BGEZ: condTrue = ~sign;
         isaPkg::SEQ:  condTrue = zero;
         // signed less-than, corrected for overflow
         isaPkg::SLT:  condTrue = sign ^ ovf;
         isaPkg::SLE:  condTrue = (sign ^ ovf) | zero;
         isaPkg::SCO:  condTrue = carry;
         // NONE and unused codes never fire
         default:      condTrue = 1'b0;
      endcase
   end

endmodule

//--- design/claAdder16.sv
// 16-bit carry-lookahead adder for the branch target
// four 4-bit groups, each with full lookahead on its bits, plus a
// second lookahead level across the groups; carry-in is always zero
`timescale 1ns/1ps

module claAdder16 (
   input  logic [15:0] a,
   input  logic [15:0] b,
   output logic [15:0] sum
);

   logic [15:0] g;
   logic [15:0] p;
   logic [15:0] c;
   logic [2:0]  grpG;
   logic [2:0]  grpP;
   logic [3:0]  grpC;

   // bit generate and propagate
   assign g = a & b;
   assign p = a ^ b;

   // group level lookahead, no carry into the whole adder
   assign grpC[0] = 1'b0;
   assign grpC[1] = grpG[0];
   assign grpC[2] = grpG[1] | (grpP[1] & grpG[0]);
   assign grpC[3] = grpG[2] | (grpP[2] & grpG[1]) | (grpP[2] & grpP[1] & grpG[0]);

   for (genvar gi = 0; gi < 4; gi++) begin : grp
      localparam int lsb = 4 * gi;

      // carries inside the group, all from the group carry-in
      assign c[lsb]   = grpC[gi];
      assign c[lsb+1] = g[lsb] | (p[lsb] & grpC[gi]);
      assign c[lsb+2] = g[lsb+1] | (p[lsb+1] & g[lsb])
                      | (p[lsb+1] & p[lsb] & grpC[gi]);
      assign c[lsb+3] = g[lsb+2] | (p[lsb+2] & g[lsb+1])
                      | (p[lsb+2] & p[lsb+1] & g[lsb])
                      | (p[lsb+2] & p[lsb+1] & p[lsb] & grpC[gi]);

      // top group's G/P would only feed a carry out we drop
      if (gi < 3) begin : gp
         assign grpP[gi] = &p[lsb+3:lsb];
         assign grpG[gi] = g[lsb+3] | (p[lsb+3] & g[lsb+2])
                         | (p[lsb+3] & p[lsb+2] & g[lsb+1])
                         | (p[lsb+3] & p[lsb+2] & p[lsb+1] & g[lsb]);
      end
   end

   assign sum = p ^ c;

endmodule

//--- design/alu.sv
// execute stage ALU
// optional inversion of either operand, then add, logic, shift or
// rotate selected by op; flags come out alongside the result
// purely combinational
`timescale 1ns/1ps

module alu (
   input  logic [isaPkg::WORD_W-1:0] a,
   input  logic [isaPkg::WORD_W-1:0] b,
   input  logic                      cin,
   input  isaPkg::aluOpE             op,
   input  logic                      invA,
   input  logic                      invB,
   output logic [isaPkg::WORD_W-1:0] result,
   output logic                      zero,
   output logic                      sign,
   output logic                      ovf,
   output logic                      carry
);

   logic [isaPkg::WORD_W-1:0]   opA;
   logic [isaPkg::WORD_W-1:0]   opB;
   logic [3:0]                  amt;
   logic [2*isaPkg::WORD_W-1:0] rolWide;
   logic [2*isaPkg::WORD_W-1:0] rorWide;
   logic [isaPkg::WORD_W:0]     addWide;
   logic                        isAdd;

   // inversion happens before anything else, so A-B is ~B plus cin
   assign opA = invA ? ~a : a;
   assign opB = invB ? ~b : b;

   // shift amount is the low nibble of the B operand
   assign amt = opB[3:0];

   // rotates via a doubled word, wrapped bits land in the kept half
   assign rolWide = {opA, opA} << amt;
   assign rorWide = {opA, opA} >> amt;

   // one extra bit keeps the carry out
   assign addWide = {1'b0, opA} + {1'b0, opB} + {{isaPkg::WORD_W{1'b0}}, cin};

   always_comb begin
      case (op)
         isaPkg::ROL: result = rolWide[2*isaPkg::WORD_W-1:isaPkg::WORD_W];
         isaPkg::SLL: result = opA << amt;
         isaPkg::ROR: result = rorWide[isaPkg::WORD_W-1:0];
         isaPkg::SRL: result = opA >> amt;
         isaPkg::ADD: result = addWide[isaPkg::WORD_W-1:0];
         isaPkg::OR:  result = opA | opB;
         isaPkg::XOR: result = opA ^ opB;
         isaPkg::AND: result = opA & opB;
         // unused opcodes give zero
         default:     result = '0;
      endcase
   end

   assign isAdd = (op == isaPkg::ADD);

   // zero and sign look at whatever the result is
   assign zero = (result == '0);
   assign sign = result[isaPkg::WORD_W-1];

   // signed overflow: same-signed inputs, result sign differs
   assign ovf = isAdd
              & (opA[isaPkg::WORD_W-1] == opB[isaPkg::WORD_W-1])
              & (addWide[isaPkg::WORD_W-1] != opA[isaPkg::WORD_W-1]);

   // carry only means something for the adder
   assign carry = isAdd & addWide[isaPkg::WORD_W];

endmodule

//--- design/pipePkg.sv
// packed structs moving through the execute stage
// control word, forwarded data, the request into the stage and the
// response out of it
// field types come from isaPkg, so compile that package first
package pipePkg;

   // decoded control for one execute operation
   typedef struct packed {
      isaPkg::aluOpE    aluOp;
      logic             invA;
      logic             invB;
      logic             cin;
      isaPkg::brCondE   brCond;
      // pick imm11 instead of imm8 for the target
      logic             immSel;
      // target base is the ALU result, not incPc
      logic             aluPcBase;
      // result word becomes the condition bit
      logic             setOp;
      // next PC is the ALU result
      logic             aluJmp;
      // link value is incPc
      logic             jal;
      // next PC is incPc
      logic             slbi;
      // ALU B operand skips forwarding
      logic             stuBase;
      isaPkg::fwdSrcE   fwdA;
      isaPkg::fwdSrcE   fwdB;
      isaPkg::storeSelE storeSel;
   } execCtrlS;

   // values forwarded back from the EX and MEM stages
   typedef struct packed {
      logic [isaPkg::WORD_W-1:0] exAlu;
      logic [isaPkg::WORD_W-1:0] exImm8;
      logic [isaPkg::WORD_W-1:0] exAddPc;
      logic [isaPkg::WORD_W-1:0] memAlu;
      logic [isaPkg::WORD_W-1:0] memImm8;
      logic [isaPkg::WORD_W-1:0] memAddPc;
      logic [isaPkg::WORD_W-1:0] memData;
   } fwdDataS;

   // one request into the execute stage
   typedef struct packed {
      execCtrlS                  ctrl;
      logic [isaPkg::WORD_W-1:0] inA;
      logic [isaPkg::WORD_W-1:0] inB;
      logic [isaPkg::WORD_W-1:0] incPc;
      // both immediates arrive already sign-extended
      logic [isaPkg::WORD_W-1:0] imm8;
      logic [isaPkg::WORD_W-1:0] imm11;
      logic [isaPkg::WORD_W-1:0] wrtDataIn;
      fwdDataS                   fwd;
   } execReqS;

   // results handed on to the memory stage
   typedef struct packed {
      logic [isaPkg::WORD_W-1:0] aluFinal;
      logic [isaPkg::WORD_W-1:0] newPc;
      logic [isaPkg::WORD_W-1:0] addPc;
      logic [isaPkg::WORD_W-1:0] aluOut;
      logic [isaPkg::WORD_W-1:0] wrtDataOut;
   } execRespS;

endpackage

//--- design/isaPkg.sv
// instruction-set encodings for the execute stage
// holds the data word width and the enums that decode places in the
// control word: ALU operations, branch/set conditions, operand
// forwarding sources and the store data choice
// reference these through isaPkg:: scoped names
package isaPkg;

   // every datapath word in this ISA is 16 bits
   localparam int WORD_W = 16;

   // ALU operations, shifts and rotates in the low half
   typedef enum logic [3:0] {
      ROL = 4'b0000,
      SLL = 4'b0001,
      ROR = 4'b0010,
      SRL = 4'b0011,
      ADD = 4'b0100,
      OR  = 4'b0101,
      XOR = 4'b0110,
      AND = 4'b0111
   } aluOpE;

   // branch conditions test the ALU result against zero,
   // set conditions compare A and B through A minus B
   typedef enum logic [3:0] {
      NONE = 4'd0,
      BEQZ = 4'd1,
      BNEZ = 4'd2,
      BLTZ = 4'd3,
      BGEZ = 4'd4,
      SEQ  = 4'd5,
      SLT  = 4'd6,
      SLE  = 4'd7,
      SCO  = 4'd8
   } brCondE;

   // where an operand comes from, register file or a later stage
   typedef enum logic [2:0] {
      REG       = 3'd0,
      EX_ALU    = 3'd1,
      EX_IMM8   = 3'd2,
      EX_ADDPC  = 3'd3,
      MEM_ALU   = 3'd4,
      MEM_IMM8  = 3'd5,
      MEM_ADDPC = 3'd6,
      MEM_MEM   = 3'd7
   } fwdSrcE;

   // store data is either forwarded B or the value passed in
   typedef enum logic {
      STD_FWD  = 1'b0,
      STD_PASS = 1'b1
   } storeSelE;

endpackage
